// ==== design/circle_fsm.sv ====
`timescale 1ns/10ps

module circle_fsm (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   start,
    input  logic        [circle_pkg::colour_width-1:0] colour,
    input  logic signed [circle_pkg::crit_width-1:0]   crit,
    input  logic signed [circle_pkg::off_width-1:0]    offset_x,
    input  logic signed [circle_pkg::off_width-1:0]    offset_y,
    input  logic                                   fill_done,
    output logic                                   done,
    output logic        [circle_pkg::colour_width-1:0] pixel_colour,
    output logic                                   draw_circle,
    output logic        [2:0]                      octant_sel,
    output logic                                   fill_en,
    output logic                                   load_init,
    output logic                                   inc_y,
    output logic                                   dec_x,
    output logic                                   step
);

    import circle_pkg::*;

    circle_state_t state;
    circle_state_t next;

    // Offsets as they will be after this iteration's update
    logic signed [off_width-1:0] next_x;
    logic signed [off_width-1:0] next_y;
    logic                        crit_pos;

    assign crit_pos = (crit > 0);
    assign next_y   = offset_y + off_width'(1);
    assign next_x   = crit_pos ? offset_x - off_width'(1) : offset_x;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= circle_idle;
        end else begin
            state <= next;
        end
    end

    always_comb begin
        next = state;
        case (state)
            circle_idle: begin
                if (start) begin
                    next = circle_load;
                end
            end
            circle_load: next = circle_black;
            circle_black: begin
                if (fill_done) begin
                    next = circle_oct1;
                end
            end
            circle_oct1: next = circle_oct2;
            circle_oct2: next = circle_oct3;
            circle_oct3: next = circle_oct4;
            circle_oct4: next = circle_oct5;
            circle_oct5: next = circle_oct6;
            circle_oct6: next = circle_oct7;
            circle_oct7: next = circle_oct8;
            circle_oct8: begin
                // Another iteration only while the arc stays above the diagonal
                if (next_y <= next_x) begin
                    next = circle_oct1;
                end else begin
                    next = circle_done;
                end
            end
            circle_done: begin
                if (!start) begin
                    next = circle_idle;
                end
            end
            default: next = circle_idle;
        endcase
    end

    always_comb begin
        done         = 1'b0;
        pixel_colour = '0;
        draw_circle  = 1'b0;
        octant_sel   = 3'd0;
        fill_en      = 1'b0;
        load_init    = 1'b0;
        inc_y        = 1'b0;
        dec_x        = 1'b0;
        step         = 1'b0;
        case (state)
            circle_load: load_init = 1'b1;
            circle_black: fill_en = 1'b1;
            circle_oct1, circle_oct2, circle_oct3, circle_oct4,
            circle_oct5, circle_oct6, circle_oct7, circle_oct8: begin
                draw_circle  = 1'b1;
                pixel_colour = colour;
                octant_sel   = 3'(state - circle_oct1);
                // Whole iteration advances once its last octant is out
                if (state == circle_oct8) begin
                    inc_y = 1'b1;
                    dec_x = crit_pos;
                    step  = 1'b1;
                end
            end
            circle_done: done = 1'b1;
            default: ;
        endcase
    end

endmodule

// ==== design/circle_pkg.sv ====
package circle_pkg;

    // Screen coordinate widths
    localparam int x_width = 8;
    localparam int y_width = 7;

    // Signed offset from the centre, wide enough for a full radius
    localparam int off_width = 9;

    // Midpoint decision value
    localparam int crit_width = 11;

    // Three-bit RGB colour
    localparam int colour_width = 3;

    // Drawer states, octant states kept consecutive for the octant index
    typedef enum logic [3:0] {
        circle_idle  = 4'd0,
        circle_load  = 4'd1,
        circle_black = 4'd2,
        circle_oct1  = 4'd3,
        circle_oct2  = 4'd4,
        circle_oct3  = 4'd5,
        circle_oct4  = 4'd6,
        circle_oct5  = 4'd7,
        circle_oct6  = 4'd8,
        circle_oct7  = 4'd9,
        circle_oct8  = 4'd10,
        circle_done  = 4'd11
    } circle_state_t;

endpackage

// ==== design/circle_top.sv ====
`timescale 1ns/10ps

module circle_top #(
    parameter int screen_w = 160,
    parameter int screen_h = 120
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                start,
    input  logic [circle_pkg::colour_width-1:0] colour,
    input  logic [circle_pkg::x_width-1:0]      centre_x,
    input  logic [circle_pkg::y_width-1:0]      centre_y,
    input  logic [circle_pkg::x_width-1:0]      radius,
    output logic                                done,
    output logic [circle_pkg::x_width-1:0]      vga_x,
    output logic [circle_pkg::y_width-1:0]      vga_y,
    output logic [circle_pkg::colour_width-1:0] vga_colour,
    output logic                                vga_plot
);

    import circle_pkg::*;

    // Datapath state seen by the FSM and the mapper
    logic signed [off_width-1:0]  offset_x;
    logic signed [off_width-1:0]  offset_y;
    logic signed [crit_width-1:0] crit;

    // FSM controls
    logic                    load_init;
    logic                    inc_y;
    logic                    dec_x;
    logic                    step;
    logic                    fill_en;
    logic                    draw_circle;
    logic [2:0]              octant_sel;
    logic [colour_width-1:0] pixel_colour;

    // Clear sweep
    logic [x_width-1:0] fill_x;
    logic [y_width-1:0] fill_y;
    logic               fill_done;

    circle_fsm fsm_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .colour       (colour),
        .crit         (crit),
        .offset_x     (offset_x),
        .offset_y     (offset_y),
        .fill_done    (fill_done),
        .done         (done),
        .pixel_colour (pixel_colour),
        .draw_circle  (draw_circle),
        .octant_sel   (octant_sel),
        .fill_en      (fill_en),
        .load_init    (load_init),
        .inc_y        (inc_y),
        .dec_x        (dec_x),
        .step         (step)
    );

    fill_counter #(
        .screen_w (screen_w),
        .screen_h (screen_h)
    ) fill_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .fill_en   (fill_en),
        .fill_x    (fill_x),
        .fill_y    (fill_y),
        .fill_done (fill_done)
    );

    midpoint_datapath dp_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .radius    (radius),
        .load_init (load_init),
        .inc_y     (inc_y),
        .dec_x     (dec_x),
        .step      (step),
        .offset_x  (offset_x),
        .offset_y  (offset_y),
        .crit      (crit)
    );

    octant_mapper #(
        .screen_w (screen_w),
        .screen_h (screen_h)
    ) map_i (
        .centre_x     (centre_x),
        .centre_y     (centre_y),
        .offset_x     (offset_x),
        .offset_y     (offset_y),
        .octant_sel   (octant_sel),
        .draw_circle  (draw_circle),
        .fill_en      (fill_en),
        .fill_x       (fill_x),
        .fill_y       (fill_y),
        .pixel_colour (pixel_colour),
        .vga_x        (vga_x),
        .vga_y        (vga_y),
        .vga_colour   (vga_colour),
        .vga_plot     (vga_plot)
    );

endmodule

// ==== design/fill_counter.sv ====
`timescale 1ns/10ps

module fill_counter #(
    parameter int screen_w = 160,
    parameter int screen_h = 120
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           fill_en,
    output logic [circle_pkg::x_width-1:0] fill_x,
    output logic [circle_pkg::y_width-1:0] fill_y,
    output logic                           fill_done
);

    import circle_pkg::*;

    localparam logic [x_width-1:0] last_x = x_width'(screen_w - 1);
    localparam logic [y_width-1:0] last_y = y_width'(screen_h - 1);

    logic end_of_row;

    assign end_of_row = (fill_x == last_x);

    // Row-major sweep, restarts whenever the clear phase is not active
    always_ff @(posedge clk) begin
        if (!rst_n || !fill_en) begin
            fill_x <= '0;
            fill_y <= '0;
        end else if (end_of_row) begin
            fill_x <= '0;
            if (fill_y == last_y) begin
                fill_y <= '0;
            end else begin
                fill_y <= fill_y + 1'b1;
            end
        end else begin
            fill_x <= fill_x + 1'b1;
        end
    end

    // High on the bottom-right pixel only
    assign fill_done = fill_en && end_of_row && (fill_y == last_y);

endmodule

// ==== design/midpoint_datapath.sv ====
`timescale 1ns/10ps

module midpoint_datapath (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic        [circle_pkg::x_width-1:0]    radius,
    input  logic                                     load_init,
    input  logic                                     inc_y,
    input  logic                                     dec_x,
    input  logic                                     step,
    output logic signed [circle_pkg::off_width-1:0]  offset_x,
    output logic signed [circle_pkg::off_width-1:0]  offset_y,
    output logic signed [circle_pkg::crit_width-1:0] crit
);

    import circle_pkg::*;

    logic signed [off_width-1:0]  new_x;
    logic signed [off_width-1:0]  new_y;
    logic signed [crit_width-1:0] x_ext;
    logic signed [crit_width-1:0] y_ext;
    logic signed [crit_width-1:0] new_crit;
    logic signed [crit_width-1:0] radius_ext;

    assign new_x = dec_x ? offset_x - off_width'(1) : offset_x;
    assign new_y = inc_y ? offset_y + off_width'(1) : offset_y;

    assign x_ext      = crit_width'(new_x);
    assign y_ext      = crit_width'(new_y);
    assign radius_ext = signed'(crit_width'(radius));

    // Branch on the old decision value, increments from the new offsets
    always_comb begin
        if (crit <= 0) begin
            new_crit = crit + (y_ext <<< 1) + crit_width'(1);
        end else begin
            new_crit = crit + ((y_ext - x_ext) <<< 1) + crit_width'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            offset_x <= '0;
            offset_y <= '0;
            crit     <= '0;
        end else if (load_init) begin
            offset_x <= signed'(off_width'(radius));
            offset_y <= '0;
            crit     <= crit_width'(1) - radius_ext;
        end else begin
            if (inc_y || dec_x) begin
                offset_x <= new_x;
                offset_y <= new_y;
            end
            if (step) begin
                crit <= new_crit;
            end
        end
    end

endmodule

// ==== design/octant_mapper.sv ====
`timescale 1ns/10ps

module octant_mapper #(
    parameter int screen_w = 160,
    parameter int screen_h = 120
) (
    input  logic        [circle_pkg::x_width-1:0]      centre_x,
    input  logic        [circle_pkg::y_width-1:0]      centre_y,
    input  logic signed [circle_pkg::off_width-1:0]    offset_x,
    input  logic signed [circle_pkg::off_width-1:0]    offset_y,
    input  logic        [2:0]                          octant_sel,
    input  logic                                       draw_circle,
    input  logic                                       fill_en,
    input  logic        [circle_pkg::x_width-1:0]      fill_x,
    input  logic        [circle_pkg::y_width-1:0]      fill_y,
    input  logic        [circle_pkg::colour_width-1:0] pixel_colour,
    output logic        [circle_pkg::x_width-1:0]      vga_x,
    output logic        [circle_pkg::y_width-1:0]      vga_y,
    output logic        [circle_pkg::colour_width-1:0] vga_colour,
    output logic                                       vga_plot
);

    import circle_pkg::*;

    // Two spare bits so centre plus or minus offset never overflows
    localparam int pt_width = off_width + 2;

    logic signed [pt_width-1:0] cx;
    logic signed [pt_width-1:0] cy;
    logic signed [pt_width-1:0] ox;
    logic signed [pt_width-1:0] oy;
    logic signed [pt_width-1:0] px;
    logic signed [pt_width-1:0] py;
    logic                       on_screen;

    assign cx = signed'(pt_width'(centre_x));
    assign cy = signed'(pt_width'(centre_y));
    assign ox = pt_width'(offset_x);
    assign oy = pt_width'(offset_y);

    always_comb begin
        case (octant_sel)
            3'd0: begin
                px = cx + ox;
                py = cy + oy;
            end
            3'd1: begin
                px = cx + oy;
                py = cy + ox;
            end
            3'd2: begin
                px = cx - oy;
                py = cy + ox;
            end
            3'd3: begin
                px = cx - ox;
                py = cy + oy;
            end
            3'd4: begin
                px = cx - ox;
                py = cy - oy;
            end
            3'd5: begin
                px = cx - oy;
                py = cy - ox;
            end
            3'd6: begin
                px = cx + oy;
                py = cy - ox;
            end
            default: begin
                px = cx + ox;
                py = cy - oy;
            end
        endcase
    end

    // Clip instead of wrapping
    assign on_screen = (px >= 0) && (px < screen_w) && (py >= 0) && (py < screen_h);

    assign vga_x      = fill_en ? fill_x : px[x_width-1:0];
    assign vga_y      = fill_en ? fill_y : py[y_width-1:0];
    assign vga_colour = fill_en ? '0 : pixel_colour;
    assign vga_plot   = fill_en || (draw_circle && on_screen);

endmodule

// ==== src.f ====
design/circle_pkg.sv
design/circle_fsm.sv
design/fill_counter.sv
design/midpoint_datapath.sv
design/octant_mapper.sv
design/circle_top.sv
testbench/tb_circle.sv

// ==== testbench/tb_circle.sv ====
`timescale 1ns/10ps

module tb_circle;

    localparam int screen_w = 160;
    localparam int screen_h = 120;
    localparam int n_runs = 7;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       start;
    logic [2:0] colour;
    logic [7:0] centre_x;
    logic [6:0] centre_y;
    logic [7:0] radius;
    logic       done;
    logic [7:0] vga_x;
    logic [6:0] vga_y;
    logic [2:0] vga_colour;
    logic       vga_plot;

    // Frame model written by the monitor, expected circle from the reference
    logic [2:0] frame [0:screen_w-1][0:screen_h-1];
    int         clear_count [0:screen_w-1][0:screen_h-1];
    bit         expected [0:screen_w-1][0:screen_h-1];
    bit         coloured_seen;
    logic [2:0] run_colour;

    int          cx_list [0:n_runs-1];
    int          cy_list [0:n_runs-1];
    int          r_list [0:n_runs-1];
    int          col_list [0:n_runs-1];
    logic [31:0] seed = 32'h92f1_9f48;
    int          errors = 0;
    longint      time_limit = 0;
    bit          limit_ready = 1'b0;

    circle_top #(.screen_w(screen_w), .screen_h(screen_h)) dut_i (
        .clk(clk), .rst_n(rst_n), .start(start), .colour(colour),
        .centre_x(centre_x), .centre_y(centre_y), .radius(radius), .done(done),
        .vga_x(vga_x), .vga_y(vga_y), .vga_colour(vga_colour), .vga_plot(vga_plot)
    );

    always #10 clk = ~clk;

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] want,
                               input string what);
        if (actual !== want) begin
            errors++;
            $display("Fail at %0t ns: %s (got %0d, expected %0d)", $time, what, actual, want);
            $display("Verification failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic next_rand(input int span, output int value);
        seed = lcg_step(seed);
        value = int'((seed >> 16) % span);
    endtask

    // Record every plot, colour 0 belongs to the clear sweep
    always @(posedge clk) begin
        if (rst_n && vga_plot) begin
            check_equal(vga_x < screen_w, 1, "plot x inside screen");
            check_equal(vga_y < screen_h, 1, "plot y inside screen");
            if (vga_colour == 3'd0) begin
                check_equal(coloured_seen, 0, "clear pixel after a circle pixel");
                clear_count[vga_x][vga_y]++;
            end else begin
                coloured_seen = 1'b1;
                check_equal(vga_colour, run_colour, "circle pixel colour");
            end
            frame[vga_x][vga_y] = vga_colour;
        end
    end

    task automatic mark(input int px, input int py);
        if (px >= 0 && px < screen_w && py >= 0 && py < screen_h) begin
            expected[px][py] = 1'b1;
        end
    endtask

    // Midpoint circle with eight-way symmetry, at least one iteration
    task automatic ref_circle(input int cx, input int cy, input int r);
        int x;
        int y;
        int d;
        foreach (expected[i, j]) expected[i][j] = 1'b0;
        x = r;
        y = 0;
        d = 1 - r;
        do begin
            mark(cx + x, cy + y);
            mark(cx + y, cy + x);
            mark(cx - y, cy + x);
            mark(cx - x, cy + y);
            mark(cx - x, cy - y);
            mark(cx - y, cy - x);
            mark(cx + y, cy - x);
            mark(cx + x, cy - y);
            y = y + 1;
            if (d > 0) begin
                x = x - 1;
                d = d + 2 * (y - x) + 1;
            end else begin
                d = d + 2 * y + 1;
            end
        end while (y <= x);
    endtask

    task automatic run_circle(input int idx, input int hold);
        @(negedge clk);
        coloured_seen = 1'b0;
        foreach (clear_count[i, j]) clear_count[i][j] = 0;
        ref_circle(cx_list[idx], cy_list[idx], r_list[idx]);
        run_colour = col_list[idx];
        colour = col_list[idx];
        centre_x = cx_list[idx];
        centre_y = cy_list[idx];
        radius = r_list[idx];
        start = 1'b1;
        do @(negedge clk); while (!done);
        // Done must hold for as long as start stays high
        repeat (hold) begin
            @(negedge clk);
            check_equal(done, 1, "done held while start high");
        end
        start = 1'b0;
        @(negedge clk);
        check_equal(done, 0, "done low after start drops");
        foreach (frame[i, j]) begin
            check_equal(clear_count[i][j], 1, "pixel cleared exactly once");
            check_equal(frame[i][j] != 3'd0, expected[i][j], "circle pixel set");
        end
    endtask

    task automatic idle_after_reset;
        repeat (20) begin
            @(negedge clk);
            check_equal(done, 0, "done low after reset");
            check_equal(vga_plot, 0, "plot low after reset");
        end
    endtask

    task automatic full_circle_shape;
        run_circle(0, 0);
    endtask

    task automatic edge_clipping;
        for (int k = 1; k <= 4; k++) begin
            run_circle(k, 0);
        end
    endtask

    task automatic handshake_restart;
        run_circle(5, 6);
        run_circle(6, 0);
    endtask

    task automatic pick_params;
        int v;
        for (int k = 0; k < n_runs; k++) begin
            next_rand(7, v);
            col_list[k] = v + 1;
            if (k >= 1 && k <= 4) begin
                // Centres close to a corner so the circle crosses two edges
                next_rand(15, v);
                cx_list[k] = (k % 2) ? v : screen_w - 1 - v;
                next_rand(15, v);
                cy_list[k] = (k < 3) ? v : screen_h - 1 - v;
                next_rand(50, v);
                r_list[k] = 20 + v;
            end else begin
                next_rand(80, v);
                cx_list[k] = 40 + v;
                next_rand(40, v);
                cy_list[k] = 40 + v;
                next_rand(31, v);
                r_list[k] = 5 + v;
            end
        end
        r_list[6] = 0;
        col_list[6] = col_list[5] % 7 + 1;
    endtask

    initial begin
        rst_n = 1'b0;
        start = 1'b0;
        colour = '0;
        centre_x = '0;
        centre_y = '0;
        radius = '0;
        pick_params();
        time_limit = longint'(screen_w * screen_h + 100) * 20;
        for (int k = 0; k < n_runs; k++) begin
            time_limit += longint'(screen_w * screen_h + 8 * r_list[k] + 100) * 20;
        end
        limit_ready = 1'b1;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        idle_after_reset();
        full_circle_shape();
        edge_clipping();
        handshake_restart();
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        wait (limit_ready);
        #(time_limit);
        $display("Watchdog timeout, the DUT did not finish the tests in time");
        $display("Verification failed");
        $fatal(1, "watchdog expired");
    end

endmodule
